// ==== common/decoder_pkg.sv ====
`default_nettype none

package decoder_pkg;

    // grid size
    localparam int grid_width_x = 4;
    localparam int grid_width_z = 1;
    localparam int grid_width_u = 5;

    localparam int pu_count_per_round = grid_width_x * grid_width_z;
    localparam int pu_count = pu_count_per_round * grid_width_u;
    localparam int aligned_pu_per_round = ((pu_count_per_round + 7) >> 3) << 3;

    // correction bits per round
    localparam int ns_count_per_round = (grid_width_x - 1) * grid_width_z;
    localparam int ew_count_per_round = (grid_width_x - 1) * grid_width_z + 1;
    localparam int ud_count_per_round = grid_width_x * grid_width_z;
    localparam int correction_count_per_round =
        ns_count_per_round + ew_count_per_round + ud_count_per_round;

    localparam int result_rounds = grid_width_u / 2;
    localparam int bytes_per_correction = (correction_count_per_round + 7) >> 3;
    localparam int maximum_delay = 2;

    localparam int iteration_width = 8;
    localparam int cycle_width = 16;
    localparam int delay_count_width = $clog2(maximum_delay + 1);
    localparam int round_count_width = $clog2(result_rounds + 1);
    localparam int byte_index_width = $clog2(bytes_per_correction);

    // output frame layout
    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = $clog2(fifo_depth);
    localparam int stats_header_bytes = 3;
    localparam int frame_bytes = stats_header_bytes + result_rounds * bytes_per_correction;
    localparam int msg_count_width = $clog2(frame_bytes);

    typedef enum logic [3:0] {
        stage_idle                  = 4'd0,
        stage_measurement_loading   = 4'd1,
        stage_grow                  = 4'd2,
        stage_merge                 = 4'd3,
        stage_peeling               = 4'd4,
        stage_result_valid          = 4'd5,
        stage_parameters_loading    = 4'd6,
        stage_measurement_preparing = 4'd7,
        stage_streaming_correction  = 4'd8
    } stage_t;

    // ns sits in the low bits of the packed round
    typedef struct packed {
        logic [ud_count_per_round-1:0] ud;
        logic [ew_count_per_round-1:0] ew;
        logic [ns_count_per_round-1:0] ns;
    } correction_round_t;

    typedef struct packed {
        logic [iteration_width-1:0] iterations;
        logic [cycle_width-1:0]     cycles;
    } decode_stats_t;

endpackage

`default_nettype wire

// ==== common/host_msg_pkg.sv ====
`default_nettype none

package host_msg_pkg;

    // command bytes from the host
    localparam logic [7:0] start_decoding_msg = 8'h01;
    localparam logic [7:0] measurement_data_header = 8'h02;

    // one accepted host byte
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } host_byte_t;

endpackage

`default_nettype wire

// ==== output_path/result_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_framer
    import decoder_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stats_push,
    input  decode_stats_t                         stats,
    input  logic                                  correction_push,
    input  logic [correction_count_per_round-1:0] correction,
    input  logic                                  output_ready,
    output logic [7:0]                            output_data,
    output logic                                  output_valid
);

    decode_stats_t stats_head;
    correction_round_t correction_in;
    correction_round_t correction_head;
    logic stats_not_empty;
    logic correction_not_empty;
    logic stats_pop;
    logic round_taken;
    logic [7:0] body_data;
    logic body_valid;
    logic body_ready;
    logic in_body;
    logic transfer;
    logic [msg_count_width-1:0] msg_count;

    assign correction_in = correction;

    sync_fifo #(.payload_t(decode_stats_t)) stats_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (stats_push),
        .push_data(stats),
        .pop      (stats_pop),
        .pop_data (stats_head),
        .not_empty(stats_not_empty)
    );

    sync_fifo #(.payload_t(correction_round_t)) correction_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (correction_push),
        .push_data(correction_in),
        .pop      (round_taken),
        .pop_data (correction_head),
        .not_empty(correction_not_empty)
    );

    width_serializer serializer (
        .clk        (clk),
        .reset      (reset),
        .round_valid(correction_not_empty),
        .round_data (correction_head),
        .byte_ready (body_ready),
        .round_taken(round_taken),
        .byte_data  (body_data),
        .byte_valid (body_valid)
    );

    assign in_body = (msg_count >= msg_count_width'(stats_header_bytes));
    assign body_ready = in_body && output_ready;

    // header bytes come from the head stats entry
    always_comb begin
        case (msg_count)
            msg_count_width'(0): output_data = stats_head.iterations;
            msg_count_width'(1): output_data = stats_head.cycles[15:8];
            msg_count_width'(2): output_data = stats_head.cycles[7:0];
            default:             output_data = body_data;
        endcase
    end

    assign output_valid = in_body ? body_valid : stats_not_empty;
    assign transfer = output_valid && output_ready;
    assign stats_pop = transfer && (msg_count == msg_count_width'(frame_bytes - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            msg_count <= '0;
        end else if (stats_pop) begin
            msg_count <= '0;
        end else if (transfer) begin
            msg_count <= msg_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== output_path/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
    import decoder_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty
);

    payload_t mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0] count;
    logic do_push;
    logic do_pop;

    // a full buffer drops the push
    assign do_push = push && (count != (fifo_addr_width + 1)'(fifo_depth));
    assign do_pop = pop && not_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // head shows without a pop
    assign pop_data = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== output_path/width_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module width_serializer
    import decoder_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              round_valid,
    input  correction_round_t round_data,
    input  logic              byte_ready,
    output logic              round_taken,
    output logic [7:0]        byte_data,
    output logic              byte_valid
);

    localparam int padded_width = bytes_per_correction * 8;

    logic [padded_width-1:0] padded;
    logic [byte_index_width-1:0] byte_index;
    logic last_byte;
    logic byte_accepted;

    // upper byte is zero padded
    assign padded = padded_width'(round_data);
    assign byte_data = padded[byte_index * 8 +: 8];
    assign byte_valid = round_valid;

    assign last_byte = (byte_index == byte_index_width'(bytes_per_correction - 1));
    assign byte_accepted = byte_valid && byte_ready;
    assign round_taken = byte_accepted && last_byte;

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_index <= '0;
        end else if (byte_accepted) begin
            if (last_byte) begin
                byte_index <= '0;
            end else begin
                byte_index <= byte_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/decoder_control_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder_control_top
    import decoder_pkg::*;
    import host_msg_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [7:0]                            input_data,
    input  logic                                  input_valid,
    output logic                                  input_ready,
    output logic [7:0]                            output_data,
    output logic                                  output_valid,
    input  logic                                  output_ready,
    input  logic [pu_count-1:0]                   busy_pe,
    input  logic [pu_count-1:0]                   odd_clusters_pe,
    output logic [aligned_pu_per_round-1:0]       measurements,
    input  logic [correction_count_per_round-1:0] correction,
    output stage_t                                global_stage
);

    host_byte_t host;
    logic start_cmd;
    logic header_cmd;
    logic round_done;
    logic [aligned_pu_per_round-1:0] round_syndrome;
    logic stats_push;
    decode_stats_t stats;
    logic correction_push;

    assign host.data = input_data;
    assign host.valid = input_valid && input_ready;

    host_command_decode decode0 (
        .clk           (clk),
        .reset         (reset),
        .host          (host),
        .stage         (global_stage),
        .start_cmd     (start_cmd),
        .header_cmd    (header_cmd),
        .round_done    (round_done),
        .round_syndrome(round_syndrome)
    );

    stage_controller controller0 (
        .clk            (clk),
        .reset          (reset),
        .start_cmd      (start_cmd),
        .header_cmd     (header_cmd),
        .round_done     (round_done),
        .round_syndrome (round_syndrome),
        .busy_pe        (busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .stage          (global_stage),
        .input_ready    (input_ready),
        .measurements   (measurements),
        .stats_push     (stats_push),
        .stats          (stats),
        .correction_push(correction_push)
    );

    result_framer framer0 (
        .clk            (clk),
        .reset          (reset),
        .stats_push     (stats_push),
        .stats          (stats),
        .correction_push(correction_push),
        .correction     (correction),
        .output_ready   (output_ready),
        .output_data    (output_data),
        .output_valid   (output_valid)
    );

endmodule

`default_nettype wire

// ==== src/host_command_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_command_decode
    import decoder_pkg::*;
    import host_msg_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  host_byte_t                      host,
    input  stage_t                          stage,
    output logic                            start_cmd,
    output logic                            header_cmd,
    output logic                            round_done,
    output logic [aligned_pu_per_round-1:0] round_syndrome
);

    logic in_idle;
    logic in_preparing;

    assign in_idle = (stage == stage_idle);
    assign in_preparing = (stage == stage_measurement_preparing);

    // command bytes only count while idle
    assign start_cmd = host.valid && in_idle && (host.data == start_decoding_msg);
    assign header_cmd = host.valid && in_idle && (host.data == measurement_data_header);

    // one syndrome byte per round
    assign round_done = host.valid && in_preparing;
    assign round_syndrome = host.data;

endmodule

`default_nettype wire

// ==== src/stage_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_controller
    import decoder_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start_cmd,
    input  logic                            header_cmd,
    input  logic                            round_done,
    input  logic [aligned_pu_per_round-1:0] round_syndrome,
    input  logic [pu_count-1:0]             busy_pe,
    input  logic [pu_count-1:0]             odd_clusters_pe,
    output stage_t                          stage,
    output logic                            input_ready,
    output logic [aligned_pu_per_round-1:0] measurements,
    output logic                            stats_push,
    output decode_stats_t                   stats,
    output logic                            correction_push
);

    logic running;
    logic busy;
    logic odd_clusters;
    logic [delay_count_width-1:0] delay_count;
    logic [round_count_width-1:0] round_count;
    logic [iteration_width-1:0] iteration_count;
    logic [cycle_width-1:0] cycle_count;
    logic delay_done;

    // array flags arrive one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            busy <= 1'b0;
            odd_clusters <= 1'b0;
        end else begin
            running <= 1'b1;
            busy <= |busy_pe;
            odd_clusters <= |odd_clusters_pe;
        end
    end

    assign delay_done = (delay_count >= delay_count_width'(maximum_delay));

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            delay_count <= '0;
            round_count <= '0;
        end else begin
            case (stage)
                stage_idle: begin
                    if (start_cmd) begin
                        stage <= stage_parameters_loading;
                    end else if (header_cmd) begin
                        stage <= stage_measurement_preparing;
                        round_count <= '0;
                    end
                end
                stage_parameters_loading: begin
                    stage <= stage_idle;
                end
                stage_measurement_preparing: begin
                    if (round_done) begin
                        stage <= stage_measurement_loading;
                        round_count <= round_count + 1'b1;
                    end
                end
                stage_measurement_loading: begin
                    if (round_count < round_count_width'(result_rounds)) begin
                        stage <= stage_measurement_preparing;
                    end else begin
                        stage <= stage_grow;
                    end
                end
                stage_grow: begin
                    stage <= stage_merge;
                    delay_count <= '0;
                    round_count <= '0;
                end
                stage_merge: begin
                    if (!delay_done) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!busy) begin
                        stage <= odd_clusters ? stage_grow : stage_peeling;
                        delay_count <= '0;
                    end
                end
                stage_peeling: begin
                    if (!delay_done) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!busy) begin
                        stage <= stage_streaming_correction;
                        delay_count <= '0;
                    end
                end
                stage_streaming_correction: begin
                    stage <= stage_result_valid;
                end
                stage_result_valid: begin
                    round_count <= round_count + 1'b1;
                    if (round_count == round_count_width'(result_rounds - 1)) begin
                        stage <= stage_idle;
                    end
                end
                default: begin
                    stage <= stage_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (round_done && stage == stage_measurement_preparing) begin
            measurements <= round_syndrome;
        end
    end

    // iteration and cycle statistics
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
            cycle_count <= '0;
        end else if (stage == stage_measurement_loading) begin
            iteration_count <= '0;
            cycle_count <= cycle_width'(1);
        end else if (stage == stage_grow || stage == stage_merge || stage == stage_peeling) begin
            cycle_count <= cycle_count + 1'b1;
            if (stage == stage_grow) begin
                iteration_count <= iteration_count + 1'b1;
            end
        end
    end

    assign input_ready = running &&
        (stage == stage_idle || stage == stage_measurement_preparing);

    assign correction_push = (stage == stage_result_valid);
    assign stats_push = correction_push && (round_count == '0);
    assign stats.iterations = iteration_count;
    assign stats.cycles = cycle_count;

endmodule

`default_nettype wire

// ==== tb.f ====
common/decoder_pkg.sv
common/host_msg_pkg.sv
src/host_command_decode.sv
src/stage_controller.sv
output_path/sync_fifo.sv
output_path/width_serializer.sv
output_path/result_framer.sv
src/decoder_control_top.sv
verification/decoder_control_tb.sv

// ==== verification/decoder_control_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder_control_tb
    import decoder_pkg::*;
    import host_msg_pkg::*;
();

    logic clk;
    logic reset;
    logic [7:0] input_data;
    logic input_valid;
    logic input_ready;
    logic [7:0] output_data;
    logic output_valid;
    logic output_ready;
    logic [pu_count-1:0] busy_pe;
    logic [pu_count-1:0] odd_clusters_pe;
    logic [aligned_pu_per_round-1:0] measurements;
    logic [correction_count_per_round-1:0] correction;
    stage_t global_stage;

    integer seed = 32'h5b89_0e25;
    int cycle_counter = 0;
    int cycle_limit = 1000;
    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int tests_run = 0;

    // processing-element model state
    int test_k = 1;
    int test_b = 0;
    int grow_count = 0;
    int merge_cycle = 0;
    int result_index = 0;
    int observed_merge_len = 0;
    stage_t prev_stage = stage_idle;
    correction_round_t model_rounds [result_rounds];

    // output side
    logic stall_enable = 1'b0;
    logic ready_pattern [256];
    logic [7:0] stall_index = '0;
    logic stall_held = 1'b0;
    logic [7:0] held_data;
    logic [7:0] frame_buf [frame_bytes];
    int frame_pos = 0;
    int frames_done = 0;
    int frames_expected = 0;
    decode_stats_t exp_stats_q [$];
    correction_round_t exp_round_q [$];

    decoder_control_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .input_data     (input_data),
        .input_valid    (input_valid),
        .input_ready    (input_ready),
        .output_data    (output_data),
        .output_valid   (output_valid),
        .output_ready   (output_ready),
        .busy_pe        (busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .measurements   (measurements),
        .correction     (correction),
        .global_stage   (global_stage)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_counter = cycle_counter + 1;
        if (cycle_counter > cycle_limit) begin
            $display("timeout: run did not complete within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic int merge_length(input int b);
        return (b + 2 > maximum_delay + 1) ? b + 2 : maximum_delay + 1;
    endfunction

    // expected statistics from the stage timing rules
    function automatic decode_stats_t expected_stats(input int k, input int b);
        decode_stats_t s;
        s.iterations = iteration_width'(k);
        s.cycles = cycle_width'(1 + k * (1 + merge_length(b)) + maximum_delay + 1);
        return s;
    endfunction

    function automatic int decode_budget(input int k, input int b, input bit stalled);
        int cycles;
        cycles = 2 + result_rounds * 4 + k * (1 + merge_length(b)) + maximum_delay + 2;
        cycles = cycles + result_rounds + frame_bytes;
        if (stalled) begin
            cycles = cycles + frame_bytes * 6;
        end
        return cycles;
    endfunction

    task automatic report_error(input string msg);
        error_count = error_count + 1;
        test_errors = test_errors + 1;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_stage(input string name, input stage_t got, input stage_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_stats(input string name, input decode_stats_t got,
                               input decode_stats_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_correction(input string name, input correction_round_t got,
                                    input correction_round_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_measurements(input logic [aligned_pu_per_round-1:0] got,
                                      input logic [aligned_pu_per_round-1:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("[FAIL] measurements got %h expected %h", got, exp);
        end
    endtask

    // processing-element model driven just after the edge
    always @(posedge clk) begin
        #1;
        if (reset) begin
            busy_pe = '0;
            odd_clusters_pe = '0;
            correction = '0;
            grow_count = 0;
            merge_cycle = 0;
        end else begin
            if (prev_stage == stage_merge && global_stage != stage_merge &&
                    merge_cycle > observed_merge_len) begin
                observed_merge_len = merge_cycle;
            end
            if (global_stage == stage_measurement_loading) begin
                grow_count = 0;
                observed_merge_len = 0;
            end
            if (global_stage == stage_grow) begin
                grow_count = grow_count + 1;
            end
            if (global_stage == stage_merge) begin
                merge_cycle = (prev_stage == stage_merge) ? merge_cycle + 1 : 1;
            end
            if (global_stage == stage_merge && merge_cycle <= test_b) begin
                busy_pe = pu_count'(1) << (merge_cycle % pu_count);
            end else begin
                busy_pe = '0;
            end
            odd_clusters_pe = (grow_count < test_k) ? pu_count'(20'h00410) : '0;
            if (global_stage == stage_streaming_correction) begin
                result_index = 0;
            end
            if (global_stage == stage_result_valid && result_index < result_rounds) begin
                correction = model_rounds[result_index];
                result_index = result_index + 1;
            end else begin
                correction = '0;
            end
            prev_stage = global_stage;
        end
    end

    always @(posedge clk) begin
        #1;
        if (stall_enable) begin
            output_ready = ready_pattern[stall_index];
            stall_index = stall_index + 1'b1;
        end else begin
            output_ready = 1'b1;
        end
    end

    task automatic compare_frame();
        decode_stats_t got_stats;
        correction_round_t got_round;
        logic [15:0] pair;
        if (exp_stats_q.size() == 0 || exp_round_q.size() < result_rounds) begin
            report_error("a frame arrived that no decode was expected to produce");
        end else begin
            got_stats = {frame_buf[0], frame_buf[1], frame_buf[2]};
            check_stats("stats header", got_stats, exp_stats_q.pop_front());
            for (int r = 0; r < result_rounds; r++) begin
                pair = {frame_buf[stats_header_bytes + 2 * r + 1],
                        frame_buf[stats_header_bytes + 2 * r]};
                check_byte("correction pad bits", pair[15:8] >> (correction_count_per_round - 8),
                           8'h00);
                got_round = pair[correction_count_per_round-1:0];
                check_correction("correction round", got_round, exp_round_q.pop_front());
            end
        end
    endtask

    // output bytes are sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (stall_held) begin
                if (!output_valid) begin
                    report_error("output_valid dropped while the output was stalled");
                end else begin
                    check_byte("output_data", output_data, held_data);
                end
            end
            stall_held = output_valid && !output_ready;
            held_data = output_data;
            if (output_valid && output_ready) begin
                frame_buf[frame_pos] = output_data;
                frame_pos = frame_pos + 1;
                if (frame_pos == frame_bytes) begin
                    compare_frame();
                    frame_pos = 0;
                    frames_done = frames_done + 1;
                end
            end
        end
    end

    task automatic build_ready_pattern();
        int idx;
        int len;
        logic level;
        idx = 0;
        level = 1'b0;
        while (idx < 256) begin
            len = 1 + ($unsigned($random(seed)) % 6);
            for (int j = 0; j < len && idx < 256; j++) begin
                ready_pattern[idx] = level;
                idx = idx + 1;
            end
            level = ~level;
        end
    endtask

    // called just after a rising edge
    task automatic send_byte(input logic [7:0] value);
        logic accepted;
        input_data = value;
        input_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = input_ready;
            @(posedge clk);
            #1;
        end
        input_valid = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_decode(input int k, input int b);
        logic [31:0] rnd;
        logic [7:0] syndrome;
        test_k = k;
        test_b = b;
        for (int r = 0; r < result_rounds; r++) begin
            rnd = $random(seed);
            model_rounds[r] = rnd[correction_count_per_round-1:0];
            exp_round_q.push_back(model_rounds[r]);
        end
        exp_stats_q.push_back(expected_stats(k, b));
        frames_expected = frames_expected + 1;
        send_byte(measurement_data_header);
        @(negedge clk);
        check_stage("global_stage", global_stage, stage_measurement_preparing);
        next_cycle();
        for (int r = 0; r < result_rounds; r++) begin
            rnd = $random(seed);
            syndrome = rnd[7:0];
            send_byte(syndrome);
            @(negedge clk);
            check_stage("global_stage", global_stage, stage_measurement_loading);
            check_measurements(measurements, syndrome);
            next_cycle();
            @(negedge clk);
            check_stage("global_stage", global_stage,
                        (r == result_rounds - 1) ? stage_grow : stage_measurement_preparing);
            next_cycle();
        end
        while (global_stage != stage_idle) begin
            next_cycle();
        end
        if (observed_merge_len != merge_length(b)) begin
            report_error($sformatf("merge lasted %0d cycles instead of %0d",
                                   observed_merge_len, merge_length(b)));
        end
    endtask

    task automatic wait_frames();
        while (frames_done < frames_expected) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        $display("test %0d %s: %0d mismatches", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        reset = 1'b1;
        input_data = '0;
        input_valid = 1'b0;
        output_ready = 1'b0;
        busy_pe = '0;
        odd_clusters_pe = '0;
        correction = '0;
        cycle_limit = 4 * (16 + 8 + decode_budget(1, 0, 0) + decode_budget(1, 0, 0) +
                           decode_budget(3, 0, 0) + decode_budget(2, 5, 0) +
                           decode_budget(2, 1, 1) + decode_budget(1, 3, 1)) + 200;
        build_ready_pattern();

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_flag("input_ready", input_ready, 1'b0);
        next_cycle();
        reset = 1'b0;

        while (!input_ready) begin
            next_cycle();
        end
        @(negedge clk);
        check_stage("global_stage", global_stage, stage_idle);
        check_flag("output_valid", output_valid, 1'b0);
        next_cycle();
        send_byte(start_decoding_msg);
        @(negedge clk);
        check_stage("global_stage", global_stage, stage_parameters_loading);
        next_cycle();
        @(negedge clk);
        check_stage("global_stage", global_stage, stage_idle);
        next_cycle();
        finish_test("reset and start command");

        run_decode(1, 0);
        wait_frames();
        finish_test("measurement loading");

        run_decode(1, 0);
        wait_frames();
        finish_test("single iteration frame");

        run_decode(3, 0);
        wait_frames();
        finish_test("three iterations");

        run_decode(2, 5);
        wait_frames();
        finish_test("busy lengthens merge");

        // frames pile up in the FIFOs while the output stalls
        stall_enable = 1'b1;
        run_decode(2, 1);
        run_decode(1, 3);
        wait_frames();
        stall_enable = 1'b0;
        finish_test("stalled back-to-back decodes");

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
